// File: verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // ====================
  // command word layout
  // ====================
  localparam int cmd_width  = 16;
  localparam int data_width = 8;
  localparam int addr_width = 7;
  // write flag, address sits just below it
  localparam int write_bit  = 15;

  // ====================
  // frame constants
  // ====================
  localparam logic start_level = 1'b0;
  localparam logic stop_level  = 1'b1;

  // idle bit times after the data byte of a write
  localparam int guard_bits = 2;

  // bit times a read waits for the reply start bit
  localparam int reply_timeout_bits = 64;

  // ====================
  // timing
  // ====================
  // 50 MHz clock at 115200 baud
  localparam int clks_per_bit_default = 434;

endpackage

`default_nettype wire

// File: verilog/uart_tx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::data_width-1:0] byte_data,
  input  logic                           byte_vld,
  output logic                           byte_rdy,
  output logic                           done,
  output logic                           tx
);

  import uart_pkg::*;

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_par, s_stop} state_t;

  state_t                          state;
  logic [$clog2(clks_per_bit)-1:0] cnt;
  logic [2:0]                      idx;
  logic [data_width-1:0]           shreg;
  logic                            par;
  logic                            bit_end;

  assign bit_end  = (int'(cnt) == clks_per_bit - 1);
  assign byte_rdy = (state == s_idle);

  // ====================
  // frame sequencing
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      cnt   <= '0;
      idx   <= '0;
      done  <= 1'b0;
      tx    <= stop_level;
    end else begin
      done <= 1'b0;
      if (state != s_idle) begin
        cnt <= bit_end ? '0 : cnt + 1'b1;
      end
      unique case (state)
        s_idle: begin
          if (byte_vld) begin
            state <= s_start;
            cnt   <= '0;
            tx    <= start_level;
          end
        end
        s_start: begin
          if (bit_end) begin
            state <= s_data;
            idx   <= '0;
            tx    <= shreg[0];
          end
        end
        s_data: begin
          if (bit_end) begin
            if (int'(idx) == data_width - 1) begin
              state <= s_par;
              tx    <= par;
            end else begin
              idx <= idx + 1'b1;
              tx  <= shreg[0];
            end
          end
        end
        s_par: begin
          if (bit_end) begin
            state <= s_stop;
            tx    <= stop_level;
          end
        end
        s_stop: begin
          // line is free once the stop bit has run its full time
          if (bit_end) begin
            state <= s_idle;
            done  <= 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // byte latch, shifted out lsb first
  always_ff @(posedge clk) begin
    if (byte_rdy && byte_vld) begin
      shreg <= byte_data;
      par   <= ^byte_data;
    end else if (bit_end && (state == s_start || state == s_data)) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_rx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rx,
  output logic                            start_seen,
  output logic                            rx_vld,
  output logic [uart_pkg::data_width-1:0] rx_data,
  output logic                            rx_perr
);

  import uart_pkg::*;

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_par, s_stop} state_t;

  state_t                          state;
  logic [$clog2(clks_per_bit)-1:0] cnt;
  logic [2:0]                      idx;
  logic                            rx_meta;
  logic                            rx_sync;
  logic                            rx_prev;
  logic [data_width-1:0]           shreg;
  logic                            par_bad;
  logic                            half_end;
  logic                            bit_end;

  assign half_end = (int'(cnt) == clks_per_bit / 2 - 1);
  assign bit_end  = (int'(cnt) == clks_per_bit - 1);

  // ====================
  // input synchronizer
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= stop_level;
      rx_sync <= stop_level;
      rx_prev <= stop_level;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ====================
  // frame sampling
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= s_idle;
      cnt        <= '0;
      idx        <= '0;
      start_seen <= 1'b0;
      rx_vld     <= 1'b0;
    end else begin
      start_seen <= 1'b0;
      rx_vld     <= 1'b0;
      cnt        <= bit_end ? '0 : cnt + 1'b1;
      unique case (state)
        s_idle: begin
          cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= s_start;
          end
        end
        s_start: begin
          // recheck at mid start bit, high again means a glitch
          if (half_end) begin
            cnt <= '0;
            idx <= '0;
            if (rx_sync == start_level) begin
              state      <= s_data;
              start_seen <= 1'b1;
            end else begin
              state <= s_idle;
            end
          end
        end
        s_data: begin
          if (bit_end) begin
            idx <= idx + 1'b1;
            if (int'(idx) == data_width - 1) begin
              state <= s_par;
            end
          end
        end
        s_par: begin
          if (bit_end) begin
            state <= s_stop;
          end
        end
        s_stop: begin
          if (bit_end) begin
            state  <= s_idle;
            rx_vld <= 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // received byte and error flags
  always_ff @(posedge clk) begin
    if (bit_end) begin
      if (state == s_data) begin
        shreg <= {rx_sync, shreg[data_width-1:1]};
      end
      if (state == s_par) begin
        par_bad <= ^{shreg, rx_sync};
      end
      if (state == s_stop) begin
        rx_data <= shreg;
        rx_perr <= par_bad || (rx_sync != stop_level);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_seq #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::cmd_width-1:0]  cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic [uart_pkg::data_width-1:0] byte_data,
  output logic                            byte_vld,
  input  logic                            byte_rdy,
  input  logic                            done,
  input  logic                            start_seen,
  input  logic                            rx_vld,
  input  logic [uart_pkg::data_width-1:0] rx_data,
  input  logic                            rx_perr,
  output logic                            read_rdy,
  output logic [uart_pkg::data_width-1:0] read_data,
  output logic                            read_err
);

  import uart_pkg::*;

  typedef enum logic [2:0] {
    st_idle, st_judge, st_send_hi, st_send_lo, st_guard, st_wait_reply, st_report
  } state_t;

  state_t                                state;
  logic [cmd_width-1:0]                  cmd_buf;
  logic                                  is_write;
  logic                                  sent;
  logic                                  got_start;
  logic [$clog2(clks_per_bit)-1:0]       cnt;
  logic [$clog2(reply_timeout_bits)-1:0] bit_cnt;
  logic                                  bit_tick;
  logic                                  timed_out;

  assign cmd_rdy   = (state == st_idle);
  assign read_rdy  = (state == st_report);
  assign byte_vld  = (state == st_send_hi || state == st_send_lo) && !sent;
  assign bit_tick  = (int'(cnt) == clks_per_bit - 1);
  assign timed_out = bit_tick && (int'(bit_cnt) == reply_timeout_bits - 1);

  // high byte is write flag plus address
  always_comb begin
    if (state == st_send_hi) begin
      byte_data = {cmd_buf[write_bit], cmd_buf[write_bit-1 -: addr_width]};
    end else begin
      byte_data = cmd_buf[data_width-1:0];
    end
  end

  // ====================
  // transaction control
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      is_write  <= 1'b0;
      sent      <= 1'b0;
      got_start <= 1'b0;
      cnt       <= '0;
      bit_cnt   <= '0;
    end else begin
      if (byte_vld && byte_rdy) begin
        sent <= 1'b1;
      end
      // bit-time timer, cleared at every frame end
      if (done) begin
        sent    <= 1'b0;
        cnt     <= '0;
        bit_cnt <= '0;
      end else if (bit_tick) begin
        cnt     <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
      unique case (state)
        st_idle: begin
          if (cmd_vld) begin
            state <= st_judge;
          end
        end
        st_judge: begin
          is_write  <= cmd_buf[write_bit];
          got_start <= 1'b0;
          state     <= st_send_hi;
        end
        st_send_hi: begin
          if (done) begin
            state <= is_write ? st_send_lo : st_wait_reply;
          end
        end
        st_send_lo: begin
          if (done) begin
            state <= st_guard;
          end
        end
        st_guard: begin
          if (bit_tick && int'(bit_cnt) == guard_bits - 1) begin
            state <= st_idle;
          end
        end
        st_wait_reply: begin
          if (start_seen) begin
            got_start <= 1'b1;
          end
          if ((got_start && rx_vld) || (!got_start && !start_seen && timed_out)) begin
            state <= st_report;
          end
        end
        st_report: state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  // command buffer and read result
  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_buf <= cmd_in;
    end
    if (state == st_wait_reply) begin
      if (got_start && rx_vld) begin
        read_data <= rx_data;
        read_err  <= rx_perr;
      end else if (!got_start && !start_seen && timed_out) begin
        read_data <= '0;
        read_err  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::cmd_width-1:0]  cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  input  logic                            rx,
  output logic                            tx,
  output logic                            read_rdy,
  output logic [uart_pkg::data_width-1:0] read_data,
  output logic                            read_err
);

  import uart_pkg::*;

  // ====================
  // sequencer to frame engines
  // ====================
  logic [data_width-1:0] byte_data;
  logic                  byte_vld;
  logic                  byte_rdy;
  logic                  done;
  logic                  start_seen;
  logic                  rx_vld;
  logic [data_width-1:0] rx_data;
  logic                  rx_perr;

  uart_cmd_seq #(
    .clks_per_bit(clks_per_bit)
  ) seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .byte_data (byte_data),
    .byte_vld  (byte_vld),
    .byte_rdy  (byte_rdy),
    .done      (done),
    .start_seen(start_seen),
    .rx_vld    (rx_vld),
    .rx_data   (rx_data),
    .rx_perr   (rx_perr),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame #(
    .clks_per_bit(clks_per_bit)
  ) tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .byte_data(byte_data),
    .byte_vld (byte_vld),
    .byte_rdy (byte_rdy),
    .done     (done),
    .tx       (tx)
  );

  uart_rx_frame #(
    .clks_per_bit(clks_per_bit)
  ) rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .start_seen(start_seen),
    .rx_vld    (rx_vld),
    .rx_data   (rx_data),
    .rx_perr   (rx_perr)
  );

endmodule

`default_nettype wire

// File: bench/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

  import uart_pkg::*;

  localparam int bit_clks = 16;
  localparam int max_cmds = 64;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [cmd_width-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic                  read_rdy;
  logic [data_width-1:0] read_data;
  logic                  read_err;

  // ====================
  // trace contents
  // ====================
  logic                  t_write    [max_cmds];
  logic [addr_width-1:0] t_addr     [max_cmds];
  logic [data_width-1:0] t_data     [max_cmds];
  byte                   t_mode     [max_cmds];
  logic [data_width-1:0] t_exp_data [max_cmds];
  logic                  t_exp_err  [max_cmds];
  int                    n_cmds = 0;

  int errors        = 0;
  int errs_before   = 0;
  int cycles        = 0;
  int cycle_limit   = 0;
  int cur           = 0;
  int frames_seen   = 0;
  int reads_seen    = 0;
  int frame_end_cyc = 0;
  int gap;

  // remote device model
  logic [data_width-1:0] mem [2**addr_width];
  logic [data_width-1:0] fr  [2];
  logic [data_width-1:0] dec_byte;
  logic                  dec_par;
  logic                  dec_stop;
  logic                  frame_busy    = 1'b0;
  logic                  reply_pending = 1'b0;
  logic                  reply_bad;
  logic [data_width-1:0] reply_byte;
  logic [31:0]           lfsr = 32'hf4e0bbd2;

  uart #(
    .clks_per_bit(bit_clks)
  ) uart_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read_data(read_data),
    .read_err (read_err)
  );

  always #5 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1, shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic log_error(input string msg);
    $display("** Error @ %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic load_trace();
    int                    fd;
    int                    ch;
    byte                   op;
    byte                   md;
    logic [data_width-1:0] a;
    logic [data_width-1:0] d;
    logic [data_width-1:0] ed;
    logic [3:0]            e;
    fd = $fopen("bench/uart_trace.txt", "r");
    if (fd != 0) begin
      while (n_cmds < max_cmds && $fscanf(fd, " %c", op) == 1) begin
        if (op == "#") begin
          ch = $fgetc(fd);
          while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else if ($fscanf(fd, "%h %h %c %h %h", a, d, md, ed, e) == 5) begin
          t_write[n_cmds]    = (op == "W");
          t_addr[n_cmds]     = a[addr_width-1:0];
          t_data[n_cmds]     = d;
          t_mode[n_cmds]     = md;
          t_exp_data[n_cmds] = ed;
          t_exp_err[n_cmds]  = e[0];
          n_cmds++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic start_test(input int k);
    cur         = k;
    frames_seen = 0;
    reads_seen  = 0;
    fr[0]       = 'x;
    fr[1]       = 'x;
    errs_before = errors;
  endtask

  task automatic finish_test(input int k);
    logic [data_width-1:0] hi;
    hi = {t_write[k], t_addr[k]};
    assert (frames_seen == (t_write[k] ? 2 : 1))
      else log_error($sformatf("test %0d: %0d frames on tx", k, frames_seen));
    assert (fr[0] === hi)
      else log_error($sformatf("test %0d: first frame %02h, expected %02h", k, fr[0], hi));
    if (t_write[k]) begin
      assert (fr[1] === t_data[k])
        else log_error($sformatf("test %0d: data frame %02h, expected %02h", k, fr[1], t_data[k]));
    end
    assert (reads_seen == (t_write[k] ? 0 : 1))
      else log_error($sformatf("test %0d: %0d read_rdy pulses", k, reads_seen));
    $display("test %0d %s addr %02h: %s", k, t_write[k] ? "W" : "R", t_addr[k],
             (errors == errs_before) ? "ok" : "FAILED");
  endtask

  // write frames update memory, a read frame queues the reply
  task automatic take_frame(input logic [data_width-1:0] b);
    if (frames_seen < 2) begin
      fr[frames_seen] = b;
    end
    frames_seen++;
    if (frames_seen == 1 && !b[data_width-1] && t_mode[cur] != "S") begin
      reply_byte    = mem[b[addr_width-1:0]];
      reply_bad     = (t_mode[cur] == "P");
      reply_pending = 1'b1;
    end
    if (frames_seen == 2 && fr[0][data_width-1]) begin
      mem[fr[0][addr_width-1:0]] = b;
    end
  endtask

  task automatic send_reply(input logic [data_width-1:0] b, input logic bad);
    rx = 1'b0;
    repeat (bit_clks) @(negedge clk);
    for (int k = 0; k < data_width; k++) begin
      rx = b[k];
      repeat (bit_clks) @(negedge clk);
    end
    rx = ^b ^ bad;
    repeat (bit_clks) @(negedge clk);
    rx = 1'b1;
    repeat (bit_clks) @(negedge clk);
  endtask

  // ====================
  // serial decoder on tx
  // ====================
  initial begin
    forever begin
      @(negedge tx);
      frame_busy = 1'b1;
      repeat (bit_clks / 2) @(negedge clk);
      assert (tx == 1'b0) else log_error("start bit on tx did not hold");
      for (int k = 0; k < data_width; k++) begin
        repeat (bit_clks) @(negedge clk);
        dec_byte[k] = tx;
      end
      repeat (bit_clks) @(negedge clk);
      dec_par = tx;
      repeat (bit_clks) @(negedge clk);
      dec_stop = tx;
      frame_busy    = 1'b0;
      frame_end_cyc = cycles;
      assert (^{dec_byte, dec_par} == 1'b0)
        else log_error($sformatf("odd parity on tx frame %02h", dec_byte));
      assert (dec_stop == 1'b1) else log_error("stop bit on tx is low");
      take_frame(dec_byte);
    end
  end

  // responder, idle gap of 1 to 8 bit times
  initial begin
    forever begin
      wait (reply_pending);
      reply_pending = 1'b0;
      gap = 1;
      for (int k = 0; k < 3; k++) begin
        lfsr = lfsr_next(lfsr);
        gap += int'(lfsr[0]) << k;
      end
      repeat (bit_clks / 2 + gap * bit_clks) @(negedge clk);
      send_reply(reply_byte, reply_bad);
    end
  end

  always @(negedge clk) begin
    if (frame_busy) begin
      assert (!cmd_rdy) else log_error("cmd_rdy high while a frame is on tx");
    end
    if (rst_n && read_rdy) begin
      reads_seen++;
      assert (read_data === t_exp_data[cur] && read_err === t_exp_err[cur])
        else log_error($sformatf("test %0d: read_data %02h read_err %b, expected %02h %b",
                                 cur, read_data, read_err, t_exp_data[cur], t_exp_err[cur]));
      if (t_mode[cur] == "S") begin
        assert (cycles - frame_end_cyc >= reply_timeout_bits * bit_clks)
          else log_error($sformatf("test %0d: timeout after only %0d cycles",
                                   cur, cycles - frame_end_cyc));
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles, test %0d not finished", cycles, cur);
      $display("Verification failed");
      $finish;
    end
  end

  // ====================
  // main sequence
  // ====================
  initial begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    for (int a = 0; a < 2**addr_width; a++) begin
      mem[a] = {a[addr_width-1:0], 1'b1} ^ 8'h3c;
    end
    load_trace();
    cycle_limit = n_cmds * (2 * 11 + guard_bits + reply_timeout_bits + 20) * bit_clks + 100;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (tx && cmd_rdy && !read_rdy)
      else log_error($sformatf("after reset tx %b cmd_rdy %b read_rdy %b",
                               tx, cmd_rdy, read_rdy));
    if (n_cmds == 0) begin
      $display("no commands could be read from bench/uart_trace.txt");
      errors++;
    end
    // next command waits on cmd_vld while the bridge is busy
    for (int i = 0; i < n_cmds; i++) begin
      cmd_in  = {t_write[i], t_addr[i], t_data[i]};
      cmd_vld = 1'b1;
      while (!cmd_rdy) @(negedge clk);
      if (i > 0) begin
        finish_test(i - 1);
      end
      start_test(i);
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    if (n_cmds > 0) begin
      while (!cmd_rdy) @(negedge clk);
      finish_test(n_cmds - 1);
    end
    $display("%0d tests run, %0d checks failed", n_cmds, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/uart_trace.txt
# op addr data mode exp_data exp_err  (hex fields, op W or R)
# mode N normal reply, P inverted parity, S silent; W lines ignore the last three
W 05 a7 N 00 0
W 12 3c N 00 0
R 05 00 N a7 0
R 12 00 N 3c 0
W 7f ff N 00 0
W 00 00 N 00 0
R 7f 00 N ff 0
R 00 00 N 00 0
R 05 00 P a7 1
R 12 00 S 00 1
W 05 5a N 00 0
R 05 00 N 5a 0
W 40 81 N 00 0
R 40 00 P 81 1
R 40 00 N 81 0
W 2a 96 N 00 0
R 2a 00 S 00 1
R 2a 00 N 96 0
W 33 01 N 00 0
R 33 00 N 01 0
W 6e c3 N 00 0
R 6e 00 N c3 0

// File: filelist.f
verilog/uart_pkg.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_seq.sv
verilog/uart.sv
bench/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - verilog/uart_pkg.sv
  - verilog/uart_tx_frame.sv
  - verilog/uart_rx_frame.sv
  - verilog/uart_cmd_seq.sv
  - verilog/uart.sv
  - target: test
    files:
      - bench/uart_tb.sv
